// ==== rtl/backend_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// operand and result width
`define BACKEND_XLEN 32

// operation tag width
`define BACKEND_TAG_W 4

// multiplier pipeline depth
`define BACKEND_MUL_STAGES 3

// requesters on the cdb arbiter
`define BACKEND_CDB_PORTS 3

`endif

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_e;

  typedef logic [2:0] func_t; // function code inside a unit

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7 // signed compare
  } alu_func_e;

  typedef enum logic [2:0] {
    MUL_LO = 3'd0,
    MUL_HU = 3'd1 // high word, unsigned
  } mul_func_e;

  typedef enum logic [2:0] {
    DIVU = 3'd0,
    REMU = 3'd1
  } div_func_e;

endpackage

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

`include "backend_config.svh"

package exec_pkg;

  typedef logic [`BACKEND_XLEN-1:0] word_t;
  typedef logic [2*`BACKEND_XLEN-1:0] dword_t; // full product
  typedef logic [`BACKEND_TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2 // waiting for the cdb
  } div_state_e;

endpackage

`default_nettype wire

// ==== rtl/exec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// operation from the issue stage to one unit
interface exec_req_if;
  logic            valid;
  logic            ready;
  exec_pkg::tag_t  tag;
  isa_pkg::func_t  func;
  exec_pkg::word_t op_a;
  exec_pkg::word_t op_b;

  modport issue (output valid, output tag, output func, output op_a, output op_b,
                 input ready);
  modport unit  (input valid, input tag, input func, input op_a, input op_b,
                 output ready);
endinterface

// result from one unit towards the cdb arbiter
interface cdb_req_if;
  logic            req;
  logic            grant;
  exec_pkg::tag_t  tag;
  exec_pkg::word_t data;

  modport unit    (output req, output tag, output data, input grant);
  modport arbiter (input req, input tag, input data, output grant);
endinterface

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            op_valid_i,
  output logic            op_ready_o,
  input  isa_pkg::unit_e  op_unit_i,
  input  isa_pkg::func_t  op_func_i,
  input  exec_pkg::tag_t  op_tag_i,
  input  exec_pkg::word_t op_a_i,
  input  exec_pkg::word_t op_b_i,
  exec_req_if.issue       alu_o,
  exec_req_if.issue       mul_o,
  exec_req_if.issue       div_o
);
  logic            full_q;
  isa_pkg::unit_e  unit_q;
  isa_pkg::func_t  func_q;
  exec_pkg::tag_t  tag_q;
  exec_pkg::word_t a_q;
  exec_pkg::word_t b_q;
  logic            sel_ready;
  logic            accept;

  always_comb begin
    case (unit_q)
      isa_pkg::UNIT_ALU: sel_ready = alu_o.ready;
      isa_pkg::UNIT_MUL: sel_ready = mul_o.ready;
      isa_pkg::UNIT_DIV: sel_ready = div_o.ready;
      default:           sel_ready = 1'b1; // unknown unit just drains
    endcase
  end

  assign op_ready_o = !full_q || sel_ready;
  assign accept     = op_valid_i && op_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (sel_ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      unit_q <= op_unit_i;
      func_q <= op_func_i;
      tag_q  <= op_tag_i;
      a_q    <= op_a_i;
      b_q    <= op_b_i;
    end
  end

  assign alu_o.valid = full_q && (unit_q == isa_pkg::UNIT_ALU);
  assign mul_o.valid = full_q && (unit_q == isa_pkg::UNIT_MUL);
  assign div_o.valid = full_q && (unit_q == isa_pkg::UNIT_DIV);

  // payload is shared, only valid is steered
  assign alu_o.tag  = tag_q;
  assign alu_o.func = func_q;
  assign alu_o.op_a = a_q;
  assign alu_o.op_b = b_q;
  assign mul_o.tag  = tag_q;
  assign mul_o.func = func_q;
  assign mul_o.op_a = a_q;
  assign mul_o.op_b = b_q;
  assign div_o.tag  = tag_q;
  assign div_o.func = func_q;
  assign div_o.op_a = a_q;
  assign div_o.op_b = b_q;

  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_o.valid, mul_o.valid, div_o.valid}));

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic     clk,
  input  logic     rst_n,
  exec_req_if.unit req_i,
  cdb_req_if.unit  cdb_o
);
  logic            full_q;
  exec_pkg::word_t res_q;
  exec_pkg::tag_t  tag_q;
  exec_pkg::word_t res;

  always_comb begin
    res = '0;
    case (isa_pkg::alu_func_e'(req_i.func))
      isa_pkg::ADD: res = req_i.op_a + req_i.op_b;
      isa_pkg::SUB: res = req_i.op_a - req_i.op_b;
      isa_pkg::AND: res = req_i.op_a & req_i.op_b;
      isa_pkg::OR:  res = req_i.op_a | req_i.op_b;
      isa_pkg::XOR: res = req_i.op_a ^ req_i.op_b;
      isa_pkg::SLL: res = req_i.op_a << req_i.op_b[4:0]; // low 5 bits only
      isa_pkg::SRL: res = req_i.op_a >> req_i.op_b[4:0];
      isa_pkg::SLT: res = exec_pkg::word_t'($signed(req_i.op_a) < $signed(req_i.op_b));
      default:      res = '0;
    endcase
  end

  // free now, or freed by this cycle's grant
  assign req_i.ready = !full_q || cdb_o.grant;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (req_i.valid && req_i.ready) begin
      full_q <= 1'b1;
    end else if (cdb_o.grant) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid && req_i.ready) begin
      res_q <= res;
      tag_q <= req_i.tag;
    end
  end

  assign cdb_o.req  = full_q;
  assign cdb_o.tag  = tag_q;
  assign cdb_o.data = res_q;

  a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_o.req && !cdb_o.grant |=> cdb_o.req && $stable(cdb_o.data));

endmodule

`default_nettype wire

// ==== rtl/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module mul_unit (
  input  logic     clk,
  input  logic     rst_n,
  exec_req_if.unit req_i,
  cdb_req_if.unit  cdb_o
);
  localparam int S = `BACKEND_MUL_STAGES;
  localparam int W = `BACKEND_XLEN;

  logic [S-1:0]     vld_q;
  exec_pkg::tag_t   tag_q  [S];
  isa_pkg::func_t   func_q [S];
  exec_pkg::dword_t prod_q [S];
  logic             stall;

  // last stage waiting on the cdb holds everything
  assign stall       = vld_q[S-1] && !cdb_o.grant;
  assign req_i.ready = !stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (!stall) begin
      vld_q[0] <= req_i.valid;
      for (int i = 1; i < S; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      tag_q[0]  <= req_i.tag;
      func_q[0] <= req_i.func;
      prod_q[0] <= exec_pkg::dword_t'(req_i.op_a) * exec_pkg::dword_t'(req_i.op_b);
      for (int i = 1; i < S; i++) begin
        tag_q[i]  <= tag_q[i-1];
        func_q[i] <= func_q[i-1];
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  assign cdb_o.req = vld_q[S-1];
  assign cdb_o.tag = tag_q[S-1];

  always_comb begin
    if (isa_pkg::mul_func_e'(func_q[S-1]) == isa_pkg::MUL_HU) begin
      cdb_o.data = prod_q[S-1][2*W-1:W];
    end else begin
      cdb_o.data = prod_q[S-1][W-1:0]; // MUL_LO
    end
  end

  a_frozen_pipe: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable(vld_q) && $stable(tag_q[0]) && $stable(prod_q[S-1]));

endmodule

`default_nettype wire

// ==== rtl/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module div_unit (
  input  logic     clk,
  input  logic     rst_n,
  exec_req_if.unit req_i,
  cdb_req_if.unit  cdb_o
);
  localparam int W     = `BACKEND_XLEN;
  localparam int CNT_W = $clog2(W);

  exec_pkg::div_state_e state_q;
  logic [CNT_W-1:0]     cnt_q;
  exec_pkg::word_t      quo_q; // dividend shifts out, quotient shifts in
  exec_pkg::word_t      rem_q;
  exec_pkg::word_t      dvs_q;
  exec_pkg::tag_t       tag_q;
  isa_pkg::func_t       func_q;
  logic [W:0]           shifted;
  logic [W:0]           diff;

  assign shifted = {rem_q, quo_q[W-1]};
  assign diff    = shifted - {1'b0, dvs_q};

  assign req_i.ready = (state_q == exec_pkg::IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= exec_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        exec_pkg::IDLE: begin
          if (req_i.valid) begin
            state_q <= exec_pkg::BUSY;
            cnt_q   <= '0;
          end
        end
        exec_pkg::BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(W - 1)) begin
            state_q <= exec_pkg::DONE;
          end
        end
        exec_pkg::DONE: begin
          if (cdb_o.grant) state_q <= exec_pkg::IDLE;
        end
        default: state_q <= exec_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == exec_pkg::IDLE && req_i.valid) begin
      quo_q  <= req_i.op_a;
      rem_q  <= '0;
      dvs_q  <= req_i.op_b;
      tag_q  <= req_i.tag;
      func_q <= req_i.func;
    end else if (state_q == exec_pkg::BUSY) begin
      // restoring step; a zero divisor never borrows
      if (!diff[W]) begin
        rem_q <= diff[W-1:0];
        quo_q <= {quo_q[W-2:0], 1'b1};
      end else begin
        rem_q <= shifted[W-1:0];
        quo_q <= {quo_q[W-2:0], 1'b0};
      end
    end
  end

  assign cdb_o.req  = (state_q == exec_pkg::DONE);
  assign cdb_o.tag  = tag_q;
  assign cdb_o.data = (func_q == isa_pkg::REMU) ? rem_q : quo_q;

  a_busy_window: assert property (@(posedge clk) disable iff (!rst_n)
    req_i.valid && req_i.ready |=> !req_i.ready [*(`BACKEND_XLEN + 1)]);

endmodule

`default_nettype wire

// ==== rtl/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module cdb_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  cdb_req_if.arbiter      port_i [`BACKEND_CDB_PORTS],
  output logic            cdb_valid_o,
  output exec_pkg::tag_t  cdb_tag_o,
  output exec_pkg::word_t cdb_data_o
);
  localparam int N     = `BACKEND_CDB_PORTS;
  localparam int PTR_W = $clog2(N);

  logic [N-1:0]     req;
  logic [N-1:0]     gnt;
  exec_pkg::tag_t   tags  [N];
  exec_pkg::word_t  datas [N];
  logic [PTR_W-1:0] last_q; // last winner
  logic [PTR_W-1:0] win;
  logic             found;

  for (genvar i = 0; i < N; i++) begin : g_port
    assign req[i]         = port_i[i].req;
    assign tags[i]        = port_i[i].tag;
    assign datas[i]       = port_i[i].data;
    assign port_i[i].grant = gnt[i];
  end

  always_comb begin
    int idx;
    found = 1'b0;
    win   = last_q;
    gnt   = '0;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last_q) + k) % N;
      if (!found && req[idx]) begin
        found = 1'b1;
        win   = PTR_W'(idx);
      end
    end
    if (found) gnt[win] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cdb_valid_o <= 1'b0;
      last_q      <= PTR_W'(N - 1); // port 0 goes first
    end else begin
      cdb_valid_o <= found;
      if (found) last_q <= win;
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      cdb_tag_o  <= tags[win];
      cdb_data_o <= datas[win];
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

`default_nettype wire

// ==== rtl/exec_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module exec_backend (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            op_valid_i,
  output logic            op_ready_o,
  input  isa_pkg::unit_e  op_unit_i,
  input  isa_pkg::func_t  op_func_i,
  input  exec_pkg::tag_t  op_tag_i,
  input  exec_pkg::word_t op_a_i,
  input  exec_pkg::word_t op_b_i,
  output logic            cdb_valid_o,
  output exec_pkg::tag_t  cdb_tag_o,
  output exec_pkg::word_t cdb_data_o
);
  exec_req_if alu_req ();
  exec_req_if mul_req ();
  exec_req_if div_req ();
  cdb_req_if  cdb_port [`BACKEND_CDB_PORTS] (); // 0 alu, 1 mul, 2 div

  issue_stage u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid_i (op_valid_i),
    .op_ready_o (op_ready_o),
    .op_unit_i  (op_unit_i),
    .op_func_i  (op_func_i),
    .op_tag_i   (op_tag_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .alu_o      (alu_req),
    .mul_o      (mul_req),
    .div_o      (div_req)
  );

  alu_unit u_alu (.clk(clk), .rst_n(rst_n), .req_i(alu_req), .cdb_o(cdb_port[0]));
  mul_unit u_mul (.clk(clk), .rst_n(rst_n), .req_i(mul_req), .cdb_o(cdb_port[1]));
  div_unit u_div (.clk(clk), .rst_n(rst_n), .req_i(div_req), .cdb_o(cdb_port[2]));

  cdb_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .port_i      (cdb_port),
    .cdb_valid_o (cdb_valid_o),
    .cdb_tag_o   (cdb_tag_o),
    .cdb_data_o  (cdb_data_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_exec_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_backend;
  localparam int CLK_PERIOD   = 8;
  localparam int MAX_REC      = 32;
  localparam int FIELDS       = 7; // test, unit, func, tag, a, b, expected
  localparam int NUM_TAGS     = 1 << $bits(exec_pkg::tag_t);
  localparam int BURST_TEST   = 5;
  localparam int RAND_TEST    = 6;
  localparam int ACCEPT_LIMIT = 200;
  localparam int DRAIN_LIMIT  = 400;

  logic            clk;
  logic            rst_n;
  logic            op_valid_i;
  logic            op_ready_o;
  isa_pkg::unit_e  op_unit_i;
  isa_pkg::func_t  op_func_i;
  exec_pkg::tag_t  op_tag_i;
  exec_pkg::word_t op_a_i;
  exec_pkg::word_t op_b_i;
  logic            cdb_valid_o;
  exec_pkg::tag_t  cdb_tag_o;
  exec_pkg::word_t cdb_data_o;

  logic [31:0]         recs [MAX_REC*FIELDS];
  exec_pkg::word_t     exp_data [NUM_TAGS]; // scoreboard by tag
  logic [NUM_TAGS-1:0] pending;
  int                  n_rec = 0;
  int                  outstanding;
  int                  errors;
  int                  stall_cycles;
  int                  tests_passed;
  int                  tests_failed;
  integer              seed;

  exec_backend DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .op_unit_i   (op_unit_i),
    .op_func_i   (op_func_i),
    .op_tag_i    (op_tag_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .cdb_valid_o (cdb_valid_o),
    .cdb_tag_o   (cdb_tag_o),
    .cdb_data_o  (cdb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    wait (n_rec != 0);
    #(n_rec * 40 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", n_rec * 40);
    $display("** FAIL **");
    $finish;
  end

  task automatic check_value(input exec_pkg::word_t got, input exec_pkg::word_t exp,
                             input string what);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // reference ALU behavior
  function automatic exec_pkg::word_t alu_model(input int func, input exec_pkg::word_t a,
                                                input exec_pkg::word_t b);
    int sh;
    sh = b & 31;
    case (func)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return a << sh;
      6: return a >> sh;
      default: begin
        if (a[31] != b[31]) return a[31] ? 32'd1 : 32'd0; // signs differ
        return (a < b) ? 32'd1 : 32'd0;
      end
    endcase
  endfunction

  always @(negedge clk) begin
    if (rst_n && cdb_valid_o) begin
      if (!pending[cdb_tag_o]) begin
        $display("result with unknown or repeated tag %0d at %0t", cdb_tag_o, $time);
        errors++;
      end else begin
        check_value(cdb_data_o, exp_data[cdb_tag_o], $sformatf("tag %0d", cdb_tag_o));
        pending[cdb_tag_o] = 1'b0;
        outstanding--;
      end
    end
  end

  // called on a falling edge, returns on the falling edge after accept
  task automatic issue_op(input isa_pkg::unit_e unit, input int func, input int tag,
                          input exec_pkg::word_t a, input exec_pkg::word_t b,
                          input exec_pkg::word_t exp);
    int   waited;
    logic taken;
    if (pending[tag]) begin
      $display("tag %0d issued while still in flight", tag);
      errors++;
    end
    op_valid_i    = 1'b1;
    op_unit_i     = unit;
    op_func_i     = isa_pkg::func_t'(func);
    op_tag_i      = exec_pkg::tag_t'(tag);
    op_a_i        = a;
    op_b_i        = b;
    exp_data[tag] = exp;
    pending[tag]  = 1'b1;
    outstanding++;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < ACCEPT_LIMIT) begin
      taken = op_ready_o;
      if (!taken) stall_cycles++;
      waited++;
      @(negedge clk);
    end
    if (!taken) begin
      $display("operation with tag %0d was never accepted", tag);
      errors++;
    end
  endtask

  task automatic wait_results();
    int waited;
    op_valid_i = 1'b0;
    waited     = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (outstanding != 0 && waited < DRAIN_LIMIT);
    if (outstanding != 0) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (pending[t]) begin
          $display("no result came back for tag %0d", t);
          errors++;
        end
      end
      pending     = '0;
      outstanding = 0;
    end
    @(negedge clk);
  endtask

  task automatic report_test(input int num, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("test %0d passed", num);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", num, errors - err_before);
    end
  endtask

  initial begin
    int              i;
    int              cur;
    int              err_before;
    int              rf;
    exec_pkg::word_t ra;
    exec_pkg::word_t rb;
    seed         = 85;
    rst_n        = 1'b0;
    op_valid_i   = 1'b0;
    op_unit_i    = isa_pkg::UNIT_ALU;
    op_func_i    = '0;
    op_tag_i     = '0;
    op_a_i       = '0;
    op_b_i       = '0;
    pending      = '0;
    outstanding  = 0;
    errors       = 0;
    stall_cycles = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int k = 0; k < MAX_REC * FIELDS; k++) recs[k] = ~k; // never a valid test number
    $readmemh("tests/exec_tests.mem", recs);
    i = 0;
    while (i < MAX_REC && recs[i*FIELDS] >= 1 && recs[i*FIELDS] < 64) i++;
    n_rec = i;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    err_before = errors;
    check_value(exec_pkg::word_t'(cdb_valid_o), '0, "cdb_valid_o after reset");
    check_value(exec_pkg::word_t'(op_ready_o), 32'd1, "op_ready_o after reset");
    report_test(1, err_before);

    if (n_rec == 0) begin
      $display("no records found in tests/exec_tests.mem");
      errors++;
    end

    i = 0;
    while (i < n_rec) begin
      cur          = recs[i*FIELDS];
      err_before   = errors;
      stall_cycles = 0;
      while (i < n_rec && recs[i*FIELDS] == cur) begin
        issue_op(isa_pkg::unit_e'(recs[i*FIELDS+1][1:0]), recs[i*FIELDS+2],
                 recs[i*FIELDS+3], recs[i*FIELDS+4], recs[i*FIELDS+5], recs[i*FIELDS+6]);
        i++;
      end
      wait_results();
      if (cur == BURST_TEST && stall_cycles == 0) begin
        $display("op_ready_o never dropped during the mixed burst");
        errors++;
      end
      report_test(cur, err_before);
    end

    err_before = errors;
    for (int t = 0; t < NUM_TAGS; t++) begin
      ra = $random(seed);
      rb = $random(seed);
      rf = $random(seed) & 7;
      issue_op(isa_pkg::UNIT_ALU, rf, t, ra, rb, alu_model(rf, ra, rb));
    end
    wait_results();
    report_test(RAND_TEST, err_before);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/exec_tests.mem ====
// test unit func tag operand_a operand_b expected
// unit 0 alu, 1 mul, 2 div; records of one test share distinct tags
02 0 0 0 00000005 00000003 00000008
02 0 1 1 00000003 00000005 fffffffe
02 0 2 2 f0f0f0f0 0ff00ff0 00f000f0
02 0 3 3 f0f0f0f0 0ff00ff0 fff0fff0
02 0 4 4 f0f0f0f0 0ff00ff0 ff00ff00
02 0 5 5 00000001 00000024 00000010
02 0 6 6 80000000 0000003f 00000001
02 0 7 7 ffffffff 00000001 00000001
02 0 7 8 00000001 ffffffff 00000000
02 0 7 9 80000000 7fffffff 00000001
03 1 0 0 00001234 00005678 06260060
03 1 1 1 ffffffff ffffffff fffffffe
03 1 0 2 ffffffff ffffffff 00000001
03 1 1 3 80000000 00000004 00000002
04 2 0 0 00000064 00000007 0000000e
04 2 1 1 00000064 00000007 00000002
04 2 0 2 12345678 00000000 ffffffff
04 2 1 3 12345678 00000000 12345678
05 2 0 0 000003e8 0000000a 00000064
05 1 0 1 00000007 00000006 0000002a
05 2 1 2 000003e8 00000003 00000001
05 0 0 3 00000100 00000011 00000111
05 1 1 4 fffffffe 00000003 00000002
05 0 4 5 0000ffff ffffffff ffff0000

// ==== src.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/exec_pkg.sv
rtl/exec_if.sv
rtl/issue_stage.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/cdb_arbiter.sv
rtl/exec_backend.sv
tests/tb_exec_backend.sv

// ==== Bender.yml ====
package:
  name: exec_backend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/exec_pkg.sv
      - rtl/exec_if.sv
      - rtl/issue_stage.sv
      - rtl/alu_unit.sv
      - rtl/mul_unit.sv
      - rtl/div_unit.sv
      - rtl/cdb_arbiter.sv
      - rtl/exec_backend.sv
  - target: test
    files:
      - tests/tb_exec_backend.sv
